// ==== project.f ====
+incdir+include
src/routerPkg.sv
src/inputPort.sv
src/switchAlloc.sv
src/outputPort.sv
src/meshRouter.sv
sim/router_assertions.sv
sim/router_tb.sv

// ==== sim/router_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "router_consts.svh"

module routerTb import routerPkg::*; ();

    localparam logic [31:0] Seed = 32'hc1e74787;
    localparam int NumPorts   = `ROUTER_NUM_PORTS;
    localparam int PhaseFlits = 20;
    localparam int DrainLimit = 3000;
    localparam int FillLimit  = 200;
    localparam int KindX      = 0;
    localparam int KindY      = 1;
    localparam int KindLocal  = 2;
    localparam int KindAny    = 3;
    localparam int KindEast   = 4;     // x hop forced east

    logic clk = 1'b0;
    logic rstN;
    flitT inD [NumPorts];
    logic inV [NumPorts];
    logic [NumPorts-1:0] outR;
    wire  [NumPorts-1:0] inRdy;
    wire  [NumPorts-1:0] outV;
    wire  flitT outD [4];
    wire  [`ROUTER_PAYLOAD_W-1:0] localPay;

    int   srcLeft [NumPorts];
    int   srcKind [NumPorts];
    int   srcSeq [NumPorts];
    logic inTaken [NumPorts];
    logic sinkStall;
    logic [NumPorts-1:0] holdOut;
    flitT sbQ [NumPorts*NumPorts][$];   // expected flits, index in*5+out
    int   sentCount;
    int   recvCount;
    string portName [NumPorts] = '{"west", "east", "north", "south", "local"};

    always #2 clk = ~clk;

    meshRouter dut0 (
        .clk(clk), .rstN(rstN),
        .westInData(inD[0]), .westInValid(inV[0]), .westInReady(inRdy[0]),
        .westOutData(outD[0]), .westOutValid(outV[0]), .westOutReady(outR[0]),
        .eastInData(inD[1]), .eastInValid(inV[1]), .eastInReady(inRdy[1]),
        .eastOutData(outD[1]), .eastOutValid(outV[1]), .eastOutReady(outR[1]),
        .northInData(inD[2]), .northInValid(inV[2]), .northInReady(inRdy[2]),
        .northOutData(outD[2]), .northOutValid(outV[2]), .northOutReady(outR[2]),
        .southInData(inD[3]), .southInValid(inV[3]), .southInReady(inRdy[3]),
        .southOutData(outD[3]), .southOutValid(outV[3]), .southOutReady(outR[3]),
        .localInData(inD[4]), .localInValid(inV[4]), .localInReady(inRdy[4]),
        .localOutPayload(localPay), .localOutValid(outV[4]), .localOutReady(outR[4])
    );

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkEqual(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            abortRun("value mismatch");
        end
    endtask

    // hop count of minLen..3, as trailing ones
    function automatic logic [2:0] thermo(int minLen);
        int n;
        n = $urandom_range(3, minLen);
        return 3'((1 << n) - 1);
    endfunction

    function automatic flitT makeFlit(int p, int kind, int seq);
        flitT f;
        int   k;
        k = kind;
        if (kind == KindAny) begin
            case (p)
                portNorth, portSouth: k = $urandom_range(2, 1);
                portLocal:            k = $urandom_range(1, 0);
                default:              k = $urandom_range(2, 0);
            endcase
        end
        f.xDir    = 1'($urandom_range(1, 0));
        f.yDir    = 1'($urandom_range(1, 0));
        f.xHops   = '0;
        f.yHops   = '0;
        f.payload = {3'(p), 9'(seq)};   // source port and sequence, unique per input
        case (k)
            KindX, KindEast: begin
                f.xHops = thermo(1);
                f.yHops = thermo(0);
                if (p == portWest || k == KindEast) f.xDir = 1'b1;
                if (p == portEast) f.xDir = 1'b0;    // never back out of east
            end
            KindY: begin
                f.yHops = thermo(1);
                if (p == portNorth) f.yDir = 1'b1;
                if (p == portSouth) f.yDir = 1'b0;
            end
            default: ;
        endcase
        return f;
    endfunction

    // x first, then y, else the flit is home
    function automatic portIdxT expectedRoute(flitT f, output flitT routed);
        routed = f;
        if (f.xHops[0]) begin
            routed.xHops = f.xHops >> 1;
            return f.xDir ? portEast : portWest;
        end
        if (f.yHops[0]) begin
            routed.yHops = f.yHops >> 1;
            return f.yDir ? portSouth : portNorth;
        end
        return portLocal;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int q = 0; q < NumPorts*NumPorts; q++) n += sbQ[q].size();
        for (int p = 0; p < NumPorts; p++) n += srcLeft[p] + int'(inV[p]);
        return n;
    endfunction

    task automatic setSources(int kW, int kE, int kN, int kS, int kL, int count);
        int kinds [NumPorts];
        kinds = '{kW, kE, kN, kS, kL};
        for (int p = 0; p < NumPorts; p++) begin
            srcKind[p] = kinds[p];
            srcLeft[p] = (kinds[p] < 0) ? 0 : count;    // negative kind keeps a source idle
        end
    endtask

    task automatic waitDrain(string what);
        int cycles;
        cycles = 0;
        while (pending() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > DrainLimit) begin
                abortRun($sformatf("timeout: %s traffic did not drain, %0d flits left",
                                   what, pending()));
            end
        end
    endtask

    task automatic waitFilled();
        int cycles;
        cycles = 0;
        while (inRdy[portWest] || inRdy[portLocal]) begin
            @(posedge clk);
            cycles++;
            if (cycles > FillLimit) begin
                abortRun("timeout: readyIn never fell on west and local with east held");
            end
        end
    endtask

    task automatic compareOutput(int o);
        flitT actual;
        flitT expected;
        int   src;
        if (o == portLocal) begin
            actual         = '0;
            actual.payload = localPay;
        end else begin
            actual = outD[o];
        end
        src = -1;
        for (int i = 0; i < NumPorts; i++) begin
            // source port tag in the top payload bits
            if (src < 0 && sbQ[i*NumPorts+o].size() > 0 &&
                sbQ[i*NumPorts+o][0].payload[11:9] == actual.payload[11:9]) src = i;
        end
        if (src < 0) begin
            abortRun($sformatf("%s output delivered payload %h that no input owed it next",
                               portName[o], actual.payload));
        end else begin
            expected = sbQ[src*NumPorts+o].pop_front();
            if (o == portLocal) checkEqual("localOutPayload", expected.payload, actual.payload);
            else checkEqual({portName[o], "OutData"}, expected, actual);
            recvCount++;
        end
    endtask

    // sources and sinks
    always @(negedge clk) begin
        for (int p = 0; p < NumPorts; p++) begin
            if (inTaken[p]) begin
                inV[p]     = 1'b0;
                inTaken[p] = 1'b0;
            end
            if (rstN && !inV[p] && srcLeft[p] > 0 && $urandom_range(3, 0) != 0) begin
                inD[p] = makeFlit(p, srcKind[p], srcSeq[p]);
                inV[p] = 1'b1;
                srcSeq[p]++;
                srcLeft[p]--;
            end
        end
        for (int o = 0; o < NumPorts; o++) begin
            outR[o] = !holdOut[o] && (!sinkStall || $urandom_range(2, 0) != 0);
        end
        if (dut0.assertChk.errCount != 0) abortRun("a bound handshake or grant assertion fired");
    end

    // input transfers feed the scoreboard
    always @(posedge clk) begin
        flitT    routed;
        portIdxT dest;
        if (rstN) begin
            for (int p = 0; p < NumPorts; p++) begin
                if (inV[p] && inRdy[p]) begin
                    dest = expectedRoute(inD[p], routed);
                    sbQ[p*NumPorts+int'(dest)].push_back(routed);
                    inTaken[p] = 1'b1;
                    sentCount++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            for (int o = 0; o < NumPorts; o++) begin
                if (outV[o] && outR[o]) compareOutput(o);
            end
        end
    end

    initial begin
        void'($urandom(Seed));
        rstN      = 1'b0;
        outR      = '0;
        sinkStall = 1'b0;
        holdOut   = '0;
        sentCount = 0;
        recvCount = 0;
        for (int p = 0; p < NumPorts; p++) begin
            inD[p]     = '0;
            inV[p]     = 1'b0;
            inTaken[p] = 1'b0;
            srcLeft[p] = 0;
            srcKind[p] = KindAny;
            srcSeq[p]  = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(posedge clk);
        for (int p = 0; p < NumPorts; p++) begin
            checkEqual({portName[p], "OutValid"}, 0, outV[p]);
            checkEqual({portName[p], "InReady"}, 1, inRdy[p]);
        end
        setSources(KindX, KindX, -1, -1, KindX, PhaseFlits);
        waitDrain("x routing");
        setSources(KindY, KindY, KindY, KindY, KindY, PhaseFlits);
        waitDrain("y routing");
        setSources(KindLocal, KindLocal, KindLocal, KindLocal, -1, PhaseFlits);
        waitDrain("local delivery");
        sinkStall = 1'b1;   // all sinks stall at random, all inputs busy
        setSources(KindAny, KindAny, KindAny, KindAny, KindAny, 3 * PhaseFlits);
        waitDrain("mixed");
        sinkStall        = 1'b0;
        holdOut[portEast] = 1'b1;
        setSources(KindEast, -1, -1, -1, KindEast, 6);
        waitFilled();
        holdOut = '0;
        waitDrain("east release");
        if (pending() != 0 || sentCount != recvCount) begin
            abortRun($sformatf("%0d flits sent but %0d received", sentCount, recvCount));
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/router_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "router_consts.svh"

module routerAssertions import routerPkg::*; (
    input logic                               clk,
    input logic                               rstN,
    input logic    [`ROUTER_NUM_PORTS-1:0]    load,
    input portIdxT [`ROUTER_NUM_PORTS-1:0]    grantSel,
    input logic    [`ROUTER_NUM_PORTS-1:0]    outValid,
    input logic    [`ROUTER_NUM_PORTS-1:0]    outReady,
    input flitT    [3:0]                      dirData,      // west, east, north, south
    input logic    [`ROUTER_PAYLOAD_W-1:0]    localPayload
);

    localparam int NumPorts = `ROUTER_NUM_PORTS;

    int errCount = 0;   // failures seen so far

    logic [NumPorts-1:0] claim [NumPorts];     // claim[in][out]

    always_comb begin
        for (int i = 0; i < NumPorts; i++) begin
            for (int o = 0; o < NumPorts; o++) begin
                claim[i][o] = load[o] && (int'(grantSel[o]) == i);
            end
        end
    end

    for (genvar i = 0; i < NumPorts; i++) begin : gOneHot
        assert property (@(posedge clk) disable iff (!rstN) $onehot0(claim[i]))
            else begin
                errCount++;
                $error("input %0d granted to several outputs", i);
            end
    end

    // a held flit that is not leaving must not be overwritten
    for (genvar o = 0; o < NumPorts; o++) begin : gBusy
        assert property (@(posedge clk) disable iff (!rstN)
            load[o] |-> !outValid[o] || outReady[o])
            else begin
                errCount++;
                $error("grant to busy output %0d", o);
            end
    end

    // a stalled output keeps its flit
    for (genvar o = 0; o < 4; o++) begin : gHold
        assert property (@(posedge clk) disable iff (!rstN)
            outValid[o] && !outReady[o] |=> outValid[o] && $stable(dirData[o]))
            else begin
                errCount++;
                $error("output %0d dropped valid or data while stalled", o);
            end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        outValid[4] && !outReady[4] |=> outValid[4] && $stable(localPayload))
        else begin
            errCount++;
            $error("local output dropped valid or payload while stalled");
        end

    assert property (@(posedge clk) !rstN |-> outValid == '0)
        else begin
            errCount++;
            $error("validOut high during reset");
        end

endmodule

bind meshRouter routerAssertions assertChk (
    .clk(clk), .rstN(rstN), .load(load), .grantSel(grantSel),
    .outValid({localOutValid, southOutValid, northOutValid, eastOutValid, westOutValid}),
    .outReady({localOutReady, southOutReady, northOutReady, eastOutReady, westOutReady}),
    .dirData({southOutData, northOutData, eastOutData, westOutData}),
    .localPayload(localOutPayload)
);

`default_nettype wire

// ==== src/meshRouter.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "router_consts.svh"

module meshRouter import routerPkg::*; (
    input  logic                            clk,
    input  logic                            rstN,
    input  flitT                            westInData,
    input  logic                            westInValid,
    output logic                            westInReady,
    output flitT                            westOutData,
    output logic                            westOutValid,
    input  logic                            westOutReady,
    input  flitT                            eastInData,
    input  logic                            eastInValid,
    output logic                            eastInReady,
    output flitT                            eastOutData,
    output logic                            eastOutValid,
    input  logic                            eastOutReady,
    input  flitT                            northInData,
    input  logic                            northInValid,
    output logic                            northInReady,
    output flitT                            northOutData,
    output logic                            northOutValid,
    input  logic                            northOutReady,
    input  flitT                            southInData,
    input  logic                            southInValid,
    output logic                            southInReady,
    output flitT                            southOutData,
    output logic                            southOutValid,
    input  logic                            southOutReady,
    input  flitT                            localInData,
    input  logic                            localInValid,
    output logic                            localInReady,
    output logic [`ROUTER_PAYLOAD_W-1:0]    localOutPayload,
    output logic                            localOutValid,
    input  logic                            localOutReady
);

    logic    [`ROUTER_NUM_PORTS-1:0] headValid;
    portIdxT [`ROUTER_NUM_PORTS-1:0] headDest;
    flitT    [`ROUTER_NUM_PORTS-1:0] headFlit;     // routed heads, crossbar inputs
    logic    [`ROUTER_NUM_PORTS-1:0] pop;
    logic    [`ROUTER_NUM_PORTS-1:0] load;
    logic    [`ROUTER_NUM_PORTS-1:0] outFree;
    portIdxT [`ROUTER_NUM_PORTS-1:0] grantSel;
    flitT                            localOutData;

    assign localOutPayload = localOutData.payload;  // PE sees only the payload

    inputPort inWest (
        .clk(clk), .rstN(rstN), .inData(westInData), .inValid(westInValid),
        .inReady(westInReady), .pop(pop[portWest]), .headValid(headValid[portWest]),
        .headDest(headDest[portWest]), .headFlit(headFlit[portWest])
    );

    inputPort inEast (
        .clk(clk), .rstN(rstN), .inData(eastInData), .inValid(eastInValid),
        .inReady(eastInReady), .pop(pop[portEast]), .headValid(headValid[portEast]),
        .headDest(headDest[portEast]), .headFlit(headFlit[portEast])
    );

    inputPort inNorth (
        .clk(clk), .rstN(rstN), .inData(northInData), .inValid(northInValid),
        .inReady(northInReady), .pop(pop[portNorth]), .headValid(headValid[portNorth]),
        .headDest(headDest[portNorth]), .headFlit(headFlit[portNorth])
    );

    inputPort inSouth (
        .clk(clk), .rstN(rstN), .inData(southInData), .inValid(southInValid),
        .inReady(southInReady), .pop(pop[portSouth]), .headValid(headValid[portSouth]),
        .headDest(headDest[portSouth]), .headFlit(headFlit[portSouth])
    );

    inputPort inLocal (
        .clk(clk), .rstN(rstN), .inData(localInData), .inValid(localInValid),
        .inReady(localInReady), .pop(pop[portLocal]), .headValid(headValid[portLocal]),
        .headDest(headDest[portLocal]), .headFlit(headFlit[portLocal])
    );

    switchAlloc alloc0 (
        .clk(clk), .rstN(rstN), .headValid(headValid), .headDest(headDest),
        .outFree(outFree), .pop(pop), .grantSel(grantSel), .load(load)
    );

    outputPort outWest (
        .clk(clk), .rstN(rstN), .candFlits(headFlit), .grantSel(grantSel[portWest]),
        .load(load[portWest]), .outData(westOutData), .outValid(westOutValid),
        .outReady(westOutReady), .outFree(outFree[portWest])
    );

    outputPort outEast (
        .clk(clk), .rstN(rstN), .candFlits(headFlit), .grantSel(grantSel[portEast]),
        .load(load[portEast]), .outData(eastOutData), .outValid(eastOutValid),
        .outReady(eastOutReady), .outFree(outFree[portEast])
    );

    outputPort outNorth (
        .clk(clk), .rstN(rstN), .candFlits(headFlit), .grantSel(grantSel[portNorth]),
        .load(load[portNorth]), .outData(northOutData), .outValid(northOutValid),
        .outReady(northOutReady), .outFree(outFree[portNorth])
    );

    outputPort outSouth (
        .clk(clk), .rstN(rstN), .candFlits(headFlit), .grantSel(grantSel[portSouth]),
        .load(load[portSouth]), .outData(southOutData), .outValid(southOutValid),
        .outReady(southOutReady), .outFree(outFree[portSouth])
    );

    outputPort outLocal (
        .clk(clk), .rstN(rstN), .candFlits(headFlit), .grantSel(grantSel[portLocal]),
        .load(load[portLocal]), .outData(localOutData), .outValid(localOutValid),
        .outReady(localOutReady), .outFree(outFree[portLocal])
    );

endmodule

`default_nettype wire

// ==== src/outputPort.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "router_consts.svh"

module outputPort import routerPkg::*; (
    input  logic                            clk,
    input  logic                            rstN,
    input  flitT [`ROUTER_NUM_PORTS-1:0]    candFlits,
    input  portIdxT                         grantSel,
    input  logic                            load,
    output flitT                            outData,
    output logic                            outValid,
    input  logic                            outReady,
    output logic                            outFree
);

    flitT selFlit;

    // crossbar column for this output
    assign selFlit = candFlits[grantSel];

    // empty, or the held flit leaves at this edge
    assign outFree = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (load) begin
            outData <= selFlit;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;   // refill, possibly back to back
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/switchAlloc.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "router_consts.svh"

module switchAlloc import routerPkg::*; (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic    [`ROUTER_NUM_PORTS-1:0]     headValid,
    input  portIdxT [`ROUTER_NUM_PORTS-1:0]     headDest,
    input  logic    [`ROUTER_NUM_PORTS-1:0]     outFree,
    output logic    [`ROUTER_NUM_PORTS-1:0]     pop,
    output portIdxT [`ROUTER_NUM_PORTS-1:0]     grantSel,
    output logic    [`ROUTER_NUM_PORTS-1:0]     load
);

    localparam int NumPorts = `ROUTER_NUM_PORTS;

    logic [NumPorts-1:0] req [NumPorts];    // req[out][in]

    // each input asks for exactly one output, its head destination
    always_comb begin
        for (int o = 0; o < NumPorts; o++) begin
            for (int i = 0; i < NumPorts; i++) begin
                req[o][i] = headValid[i] && (int'(headDest[i]) == o);
            end
        end
    end

    for (genvar o = 0; o < NumPorts; o++) begin : gArb
        portIdxT rrPtr;     // first input searched this cycle
        portIdxT winner;
        logic    found;

        always_comb begin
            int idx;
            found  = 1'b0;
            winner = rrPtr;
            for (int k = 0; k < NumPorts; k++) begin
                idx = (int'(rrPtr) + k) % NumPorts;
                if (!found && req[o][idx]) begin
                    found  = 1'b1;
                    winner = portIdxT'(idx);
                end
            end
        end

        // no grant while the output register is still occupied
        assign load[o]     = found && outFree[o];
        assign grantSel[o] = winner;

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                rrPtr <= portWest;
            end else if (load[o]) begin
                // next search starts just after the winner
                if (int'(winner) == NumPorts - 1) begin
                    rrPtr <= portWest;
                end else begin
                    rrPtr <= portIdxT'(winner + 3'd1);
                end
            end
        end
    end

    // pop the input that won somewhere, at most one output per input
    always_comb begin
        pop = '0;
        for (int o = 0; o < NumPorts; o++) begin
            for (int i = 0; i < NumPorts; i++) begin
                if (load[o] && int'(grantSel[o]) == i) begin
                    pop[i] = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/inputPort.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "router_consts.svh"

module inputPort import routerPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  flitT    inData,
    input  logic    inValid,
    output logic    inReady,
    input  logic    pop,
    output logic    headValid,
    output portIdxT headDest,
    output flitT    headFlit
);

    localparam int Depth = `ROUTER_FIFO_DEPTH;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);
    localparam logic [CntW-1:0] FullCnt = CntW'(Depth);
    localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);

    flitT            mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            push;
    logic            doPop;
    flitT            rawHead;

    assign headValid = (count != '0);
    assign doPop     = pop && headValid;
    // a full FIFO still accepts when its head leaves this cycle
    assign inReady   = (count != FullCnt) || doPop;
    assign push      = inValid && inReady;
    assign rawHead   = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
            end
            case ({push, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push with pop
            endcase
        end
    end

    // dimension order, x hops are used up before any y hop
    always_comb begin
        headFlit = rawHead;
        headDest = portLocal;   // nothing left to travel
        if (rawHead.xHops[0]) begin
            headFlit.xHops = {1'b0, rawHead.xHops[`ROUTER_HOP_W-1:1]};
            headDest       = rawHead.xDir ? portEast : portWest;
        end else if (rawHead.yHops[0]) begin
            headFlit.yHops = {1'b0, rawHead.yHops[`ROUTER_HOP_W-1:1]};
            headDest       = rawHead.yDir ? portSouth : portNorth;
        end
    end

endmodule

`default_nettype wire

// ==== src/routerPkg.sv ====
`default_nettype none

`include "router_consts.svh"

package routerPkg;

    // one flit, xDir at the top bit
    typedef struct packed {
        logic                         xDir;    // 0 west, 1 east
        logic                         yDir;    // 0 north, 1 south
        logic [`ROUTER_HOP_W-1:0]     xHops;
        logic [`ROUTER_HOP_W-1:0]     yHops;
        logic [`ROUTER_PAYLOAD_W-1:0] payload;
    } flitT;

    // router port numbering, also used as arbiter input index
    typedef enum logic [2:0] {
        portWest  = 3'd0,
        portEast  = 3'd1,
        portNorth = 3'd2,
        portSouth = 3'd3,
        portLocal = 3'd4
    } portIdxT;

endpackage

`default_nettype wire

// ==== include/router_consts.svh ====
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// flit layout from msb: xDir, yDir, xHops, yHops, payload
`define ROUTER_FLIT_W 20

// data part delivered to the local PE
`define ROUTER_PAYLOAD_W 12

// thermometer code, last bit marks a pending hop
`define ROUTER_HOP_W 3

// west, east, north, south, local
`define ROUTER_NUM_PORTS 5

// entries per input FIFO
`define ROUTER_FIFO_DEPTH 2

`endif
